// File: Makefile
# Verilator flow for the scoreboard back end

VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/sb_cfg.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
  input  logic              clock,
  input  logic              reset,
  input  logic              start_i,
  input  sb_pkg::fu_op_t    op_i,
  input  sb_pkg::data_t     opa_i,
  input  sb_pkg::data_t     opb_i,
  input  sb_pkg::trans_id_t id_i,
  output logic              wb_valid_o,
  output sb_pkg::trans_id_t wb_id_o,
  output sb_pkg::data_t     wb_data_o
);

  sb_pkg::data_t result;

  always_comb begin
    case (op_i)
      // immediate arrives on opb
      sb_pkg::OP_LI:  result = opb_i;
      sb_pkg::OP_ADD: result = opa_i + opb_i;
      sb_pkg::OP_SUB: result = opa_i - opb_i;
      sb_pkg::OP_AND: result = opa_i & opb_i;
      sb_pkg::OP_XOR: result = opa_i ^ opb_i;
      default:        result = '0;
    endcase
  end

  // ------------------------------
  // write-back port 0
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= start_i;
    end
  end

  always_ff @(posedge clock) begin
    if (start_i) begin
      wb_id_o <= id_i;
      wb_data_o <= result;
    end
  end

endmodule

// File: design/backend_top.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module backend_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              instr_valid_i,
  input  sb_pkg::fu_op_t    op_i,
  input  sb_pkg::reg_addr_t rd_i,
  input  sb_pkg::reg_addr_t rs1_i,
  input  sb_pkg::reg_addr_t rs2_i,
  input  sb_pkg::data_t     imm_i,
  output logic              instr_ack_o,
  output logic              commit_valid_o,
  output sb_pkg::reg_addr_t commit_rd_o,
  output sb_pkg::data_t     commit_data_o
);

  // ------------------------------
  // nets
  // ------------------------------
  logic issue_valid;
  sb_pkg::trans_id_t issue_id;
  logic dispatch_ok;
  sb_pkg::sb_vec_t fwd_issued;
  sb_pkg::sb_vec_t fwd_done;
  sb_pkg::reg_addr_t [`SB_DEPTH-1:0] fwd_rd;
  sb_pkg::data_t [`SB_DEPTH-1:0] fwd_result;

  // write-back bus, port 0 alu and port 1 multiplier
  logic [`WB_PORTS-1:0] wb_valid;
  sb_pkg::trans_id_t [`WB_PORTS-1:0] wb_id;
  sb_pkg::data_t [`WB_PORTS-1:0] wb_data;

  sb_pkg::reg_addr_t rf_addr1;
  sb_pkg::reg_addr_t rf_addr2;
  sb_pkg::data_t rf_data1;
  sb_pkg::data_t rf_data2;

  logic alu_start;
  logic mult_start;
  logic mult_busy;
  sb_pkg::fu_op_t fu_op;
  sb_pkg::data_t opa;
  sb_pkg::data_t opb;
  sb_pkg::trans_id_t fu_id;

  // ------------------------------
  // instances
  // ------------------------------
  scoreboard u_scoreboard (
    .clock(clock), .reset(reset), .instr_valid_i(instr_valid_i),
    .dispatch_ok_i(dispatch_ok), .rd_i(rd_i),
    .wb_valid_i(wb_valid), .wb_id_i(wb_id), .wb_data_i(wb_data),
    .issue_valid_o(issue_valid), .instr_ack_o(instr_ack_o), .issue_id_o(issue_id),
    .fwd_issued_o(fwd_issued), .fwd_done_o(fwd_done),
    .fwd_rd_o(fwd_rd), .fwd_result_o(fwd_result),
    .commit_valid_o(commit_valid_o), .commit_rd_o(commit_rd_o),
    .commit_data_o(commit_data_o)
  );

  operand_read u_operand_read (
    .clock(clock), .reset(reset), .instr_valid_i(instr_valid_i), .op_i(op_i),
    .rs1_i(rs1_i), .rs2_i(rs2_i), .imm_i(imm_i),
    .issue_valid_i(issue_valid), .issue_id_i(issue_id),
    .fwd_issued_i(fwd_issued), .fwd_done_i(fwd_done),
    .fwd_rd_i(fwd_rd), .fwd_result_i(fwd_result),
    .wb_valid_i(wb_valid), .wb_id_i(wb_id), .wb_data_i(wb_data),
    .rf_data1_i(rf_data1), .rf_data2_i(rf_data2), .mult_busy_i(mult_busy),
    .rf_addr1_o(rf_addr1), .rf_addr2_o(rf_addr2), .dispatch_ok_o(dispatch_ok),
    .alu_start_o(alu_start), .mult_start_o(mult_start),
    .op_o(fu_op), .opa_o(opa), .opb_o(opb), .id_o(fu_id)
  );

  alu_unit u_alu_unit (
    .clock(clock), .reset(reset), .start_i(alu_start), .op_i(fu_op),
    .opa_i(opa), .opb_i(opb), .id_i(fu_id),
    .wb_valid_o(wb_valid[0]), .wb_id_o(wb_id[0]), .wb_data_o(wb_data[0])
  );

  mult_unit u_mult_unit (
    .clock(clock), .reset(reset), .start_i(mult_start),
    .opa_i(opa), .opb_i(opb), .id_i(fu_id), .busy_o(mult_busy),
    .wb_valid_o(wb_valid[1]), .wb_id_o(wb_id[1]), .wb_data_o(wb_data[1])
  );

  reg_file u_reg_file (
    .clock(clock), .reset(reset), .we_i(commit_valid_o),
    .waddr_i(commit_rd_o), .wdata_i(commit_data_o),
    .raddr1_i(rf_addr1), .raddr2_i(rf_addr2),
    .rdata1_o(rf_data1), .rdata2_o(rf_data2)
  );

endmodule

// File: design/mult_unit.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module mult_unit (
  input  logic              clock,
  input  logic              reset,
  input  logic              start_i,
  input  sb_pkg::data_t     opa_i,
  input  sb_pkg::data_t     opb_i,
  input  sb_pkg::trans_id_t id_i,
  output logic              busy_o,
  output logic              wb_valid_o,
  output sb_pkg::trans_id_t wb_id_o,
  output sb_pkg::data_t     wb_data_o
);

  sb_pkg::mult_state_t state_q;
  sb_pkg::data_t mcand_q;
  sb_pkg::data_t mplier_q;
  sb_pkg::data_t acc_q;
  sb_pkg::trans_id_t id_q;

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= sb_pkg::MULT_IDLE;
    end else begin
      case (state_q)
        sb_pkg::MULT_IDLE: if (start_i) state_q <= sb_pkg::MULT_RUN;
        // last step when no multiplier bits remain above bit 0
        sb_pkg::MULT_RUN:  if (mplier_q[`XLEN-1:1] == '0) state_q <= sb_pkg::MULT_DONE;
        sb_pkg::MULT_DONE: state_q <= sb_pkg::MULT_IDLE;
        default:           state_q <= sb_pkg::MULT_IDLE;
      endcase
    end
  end

  // shift-add, low XLEN bits only
  always_ff @(posedge clock) begin
    if (start_i) begin
      mcand_q <= opa_i;
      mplier_q <= opb_i;
      acc_q <= '0;
      id_q <= id_i;
    end else if (state_q == sb_pkg::MULT_RUN) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // ------------------------------
  // write-back port 1
  // ------------------------------
  assign busy_o = (state_q != sb_pkg::MULT_IDLE);
  assign wb_valid_o = (state_q == sb_pkg::MULT_DONE);
  assign wb_id_o = id_q;
  assign wb_data_o = acc_q;

  // operand stage holds a mul back while this unit works
  a_no_start_busy: assert property (@(posedge clock) disable iff (reset)
    start_i |-> !busy_o);

endmodule

// File: design/operand_read.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module operand_read (
  input  logic                                     clock,
  input  logic                                     reset,
  input  logic                                     instr_valid_i,
  input  sb_pkg::fu_op_t                           op_i,
  input  sb_pkg::reg_addr_t                        rs1_i,
  input  sb_pkg::reg_addr_t                        rs2_i,
  input  sb_pkg::data_t                            imm_i,
  input  logic                                     issue_valid_i,
  input  sb_pkg::trans_id_t                        issue_id_i,
  input  sb_pkg::sb_vec_t                          fwd_issued_i,
  input  sb_pkg::sb_vec_t                          fwd_done_i,
  input  sb_pkg::reg_addr_t [`SB_DEPTH-1:0]        fwd_rd_i,
  input  sb_pkg::data_t     [`SB_DEPTH-1:0]        fwd_result_i,
  input  logic              [`WB_PORTS-1:0]        wb_valid_i,
  input  sb_pkg::trans_id_t [`WB_PORTS-1:0]        wb_id_i,
  input  sb_pkg::data_t     [`WB_PORTS-1:0]        wb_data_i,
  input  sb_pkg::data_t                            rf_data1_i,
  input  sb_pkg::data_t                            rf_data2_i,
  input  logic                                     mult_busy_i,
  output sb_pkg::reg_addr_t                        rf_addr1_o,
  output sb_pkg::reg_addr_t                        rf_addr2_o,
  output logic                                     dispatch_ok_o,
  output logic                                     alu_start_o,
  output logic                                     mult_start_o,
  output sb_pkg::fu_op_t                           op_o,
  output sb_pkg::data_t                            opa_o,
  output sb_pkg::data_t                            opb_o,
  output sb_pkg::trans_id_t                        id_o
);

  // msb is the stall flag, the rest is the operand
  logic [`XLEN:0] res1;
  logic [`XLEN:0] res2;
  logic uses_regs;
  logic src_stall;
  logic unit_busy;

  // youngest older producer wins, then the wb bus, then the register file
  function automatic logic [`XLEN:0] resolve_src(input sb_pkg::reg_addr_t rs,
                                                 input sb_pkg::data_t rf_data);
    sb_pkg::trans_id_t idx;
    logic found;
    logic stall;
    sb_pkg::data_t value;
    found = 1'b0;
    stall = 1'b0;
    value = rf_data;
    for (int unsigned k = 1; k < `SB_DEPTH; k++) begin
      idx = issue_id_i - sb_pkg::trans_id_t'(k);
      if (!found && fwd_issued_i[idx] && fwd_rd_i[idx] == rs) begin
        found = 1'b1;
        if (fwd_done_i[idx]) begin
          value = fwd_result_i[idx];
        end else begin
          stall = 1'b1;
          for (int unsigned p = 0; p < `WB_PORTS; p++) begin
            if (wb_valid_i[p] && wb_id_i[p] == idx) begin
              stall = 1'b0;
              value = wb_data_i[p];
            end
          end
        end
      end
    end
    // x0 producers still retire, but x0 reads stay zero
    if (rs == '0) begin
      stall = 1'b0;
      value = '0;
    end
    return {stall, value};
  endfunction

  always_comb begin
    res1 = resolve_src(rs1_i, rf_data1_i);
    res2 = resolve_src(rs2_i, rf_data2_i);
  end

  // ------------------------------
  // dispatch
  // ------------------------------
  assign rf_addr1_o = rs1_i;
  assign rf_addr2_o = rs2_i;

  // li reads no registers
  assign uses_regs = (op_i != sb_pkg::OP_LI);
  assign src_stall = uses_regs && (res1[`XLEN] || res2[`XLEN]);
  assign unit_busy = (op_i == sb_pkg::OP_MUL) && mult_busy_i;
  assign dispatch_ok_o = instr_valid_i && !src_stall && !unit_busy;

  assign alu_start_o = issue_valid_i && dispatch_ok_o && (op_i != sb_pkg::OP_MUL);
  assign mult_start_o = issue_valid_i && dispatch_ok_o && (op_i == sb_pkg::OP_MUL);

  assign op_o = op_i;
  assign opa_o = res1[`XLEN-1:0];
  assign opb_o = uses_regs ? res2[`XLEN-1:0] : imm_i;
  assign id_o = issue_id_i;

  // one unit per instruction, and the multiplier turns busy right after
  a_one_start: assert property (@(posedge clock) disable iff (reset)
    mult_start_o |-> !alu_start_o ##1 !mult_start_o);

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module reg_file (
  input  logic              clock,
  input  logic              reset,
  input  logic              we_i,
  input  sb_pkg::reg_addr_t waddr_i,
  input  sb_pkg::data_t     wdata_i,
  input  sb_pkg::reg_addr_t raddr1_i,
  input  sb_pkg::reg_addr_t raddr2_i,
  output sb_pkg::data_t     rdata1_o,
  output sb_pkg::data_t     rdata2_o
);

  // no storage behind x0
  sb_pkg::data_t regs_q [1:`NR_REGS-1];

  // ------------------------------
  // commit write port
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int unsigned i = 1; i < `NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // ------------------------------
  // read ports
  // ------------------------------
  always_comb begin
    if (raddr1_i == '0) begin
      rdata1_o = '0;
    end else begin
      rdata1_o = regs_q[raddr1_i];
    end
  end

  always_comb begin
    if (raddr2_i == '0) begin
      rdata2_o = '0;
    end else begin
      rdata2_o = regs_q[raddr2_i];
    end
  end

endmodule

// File: design/sb_pkg.sv
`include "sb_cfg.svh"

package sb_pkg;

  // ------------------------------
  // vectors with a meaning
  // ------------------------------
  typedef logic [`XLEN-1:0] data_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [`SB_INDEX-1:0] trans_id_t;
  // one flag per slot
  typedef logic [`SB_DEPTH-1:0] sb_vec_t;

  // ------------------------------
  // operations
  // ------------------------------
  typedef enum logic [2:0] {
    OP_LI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR,
    OP_MUL
  } fu_op_t;

  // iterative multiplier
  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_RUN,
    MULT_DONE
  } mult_state_t;

endpackage

// File: design/scoreboard.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module scoreboard (
  input  logic                                     clock,
  input  logic                                     reset,
  input  logic                                     instr_valid_i,
  input  logic                                     dispatch_ok_i,
  input  sb_pkg::reg_addr_t                        rd_i,
  input  logic              [`WB_PORTS-1:0]        wb_valid_i,
  input  sb_pkg::trans_id_t [`WB_PORTS-1:0]        wb_id_i,
  input  sb_pkg::data_t     [`WB_PORTS-1:0]        wb_data_i,
  output logic                                     issue_valid_o,
  output logic                                     instr_ack_o,
  output sb_pkg::trans_id_t                        issue_id_o,
  output sb_pkg::sb_vec_t                          fwd_issued_o,
  output sb_pkg::sb_vec_t                          fwd_done_o,
  output sb_pkg::reg_addr_t [`SB_DEPTH-1:0]        fwd_rd_o,
  output sb_pkg::data_t     [`SB_DEPTH-1:0]        fwd_result_o,
  output logic                                     commit_valid_o,
  output sb_pkg::reg_addr_t                        commit_rd_o,
  output sb_pkg::data_t                            commit_data_o
);

  // slot control
  sb_pkg::sb_vec_t issued_q;
  sb_pkg::sb_vec_t done_q;
  sb_pkg::trans_id_t issue_ptr_q;
  sb_pkg::trans_id_t commit_ptr_q;

  // slot payload
  sb_pkg::reg_addr_t [`SB_DEPTH-1:0] rd_q;
  sb_pkg::data_t [`SB_DEPTH-1:0] result_q;

  logic [`SB_INDEX:0] count;
  logic full;
  logic [`WB_PORTS-1:0] wb_take;

  // ------------------------------
  // occupancy and issue
  // ------------------------------
  always_comb begin
    count = '0;
    for (int unsigned i = 0; i < `SB_DEPTH; i++) begin
      count = count + {{`SB_INDEX{1'b0}}, issued_q[i]};
    end
  end

  assign full = (count == (`SB_INDEX+1)'(`SB_DEPTH));

  assign issue_valid_o = instr_valid_i && !full;
  // operand stage must also agree before the producer sees an ack
  assign instr_ack_o = issue_valid_o && dispatch_ok_i;
  assign issue_id_o = issue_ptr_q;

  // only slots still in flight take a result
  always_comb begin
    for (int unsigned p = 0; p < `WB_PORTS; p++) begin
      wb_take[p] = wb_valid_i[p] && issued_q[wb_id_i[p]];
    end
  end

  // ------------------------------
  // commit and forwarding view
  // ------------------------------
  assign commit_valid_o = issued_q[commit_ptr_q] && done_q[commit_ptr_q];
  assign commit_rd_o = rd_q[commit_ptr_q];
  assign commit_data_o = result_q[commit_ptr_q];

  assign fwd_issued_o = issued_q;
  assign fwd_done_o = done_q;
  assign fwd_rd_o = rd_q;
  assign fwd_result_o = result_q;

  // ------------------------------
  // state update
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      issued_q <= '0;
      done_q <= '0;
      issue_ptr_q <= '0;
      commit_ptr_q <= '0;
    end else begin
      if (instr_ack_o) begin
        issued_q[issue_ptr_q] <= 1'b1;
        done_q[issue_ptr_q] <= 1'b0;
        issue_ptr_q <= issue_ptr_q + sb_pkg::trans_id_t'(1);
      end
      for (int unsigned p = 0; p < `WB_PORTS; p++) begin
        if (wb_take[p]) begin
          done_q[wb_id_i[p]] <= 1'b1;
        end
      end
      // head leaves the table on the same edge as the register write
      if (commit_valid_o) begin
        issued_q[commit_ptr_q] <= 1'b0;
        done_q[commit_ptr_q] <= 1'b0;
        commit_ptr_q <= commit_ptr_q + sb_pkg::trans_id_t'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (instr_ack_o) begin
      rd_q[issue_ptr_q] <= rd_i;
    end
    for (int unsigned p = 0; p < `WB_PORTS; p++) begin
      if (wb_take[p]) begin
        result_q[wb_id_i[p]] <= wb_data_i[p];
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // an acked slot is free, so a full table never acks
  a_ack_free: assert property (@(posedge clock) disable iff (reset)
    instr_ack_o |-> !issued_q[issue_ptr_q]);

  for (genvar p = 0; p < `WB_PORTS; p++) begin : g_wb_chk
    a_wb_issued: assert property (@(posedge clock) disable iff (reset)
      wb_valid_i[p] |-> issued_q[wb_id_i[p]]);
  end

endmodule

// File: include/sb_cfg.svh
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// ------------------------------
// scoreboard geometry
// ------------------------------

// slots in flight, power of two
`define SB_DEPTH 4
// bits of a transaction id
`define SB_INDEX 2
// port 0 alu, port 1 multiplier
`define WB_PORTS 2

// ------------------------------
// datapath
// ------------------------------
`define XLEN 32
`define NR_REGS 32

`endif

// File: tests/backend_tb.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module backend_tb;

  localparam int RESET_CYCLES = 16;

  logic clock;
  logic reset;
  logic instr_valid_i;
  sb_pkg::fu_op_t op_i;
  sb_pkg::reg_addr_t rd_i;
  sb_pkg::reg_addr_t rs1_i;
  sb_pkg::reg_addr_t rs2_i;
  sb_pkg::data_t imm_i;
  logic instr_ack_o;
  logic commit_valid_o;
  sb_pkg::reg_addr_t commit_rd_o;
  sb_pkg::data_t commit_data_o;

  // instruction table
  string tbl_name [$];
  sb_pkg::fu_op_t tbl_op [$];
  sb_pkg::reg_addr_t tbl_rd [$];
  sb_pkg::reg_addr_t tbl_rs1 [$];
  sb_pkg::reg_addr_t tbl_rs2 [$];
  sb_pkg::data_t tbl_imm [$];

  // expected commits in program order
  string exp_name [$];
  sb_pkg::reg_addr_t exp_rd [$];
  sb_pkg::data_t exp_data [$];

  sb_pkg::data_t ref_regs [`NR_REGS];
  logic [31:0] lfsr_q;
  logic table_ready;
  int mismatch_errors;
  int other_errors;
  int accepted_cnt;
  int committed_cnt;

  backend_top DUT (
    .clock(clock), .reset(reset), .instr_valid_i(instr_valid_i), .op_i(op_i),
    .rd_i(rd_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .imm_i(imm_i),
    .instr_ack_o(instr_ack_o), .commit_valid_o(commit_valid_o),
    .commit_rd_o(commit_rd_o), .commit_data_o(commit_data_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ------------------------------
  // stimulus generation
  // ------------------------------
  // taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output sb_pkg::data_t value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value = {value[`XLEN-2:0], lfsr_q[0]};
    end
  endtask

  // appends one entry and runs it through the register model
  task automatic add_instr(input string name, input sb_pkg::fu_op_t op,
                           input sb_pkg::reg_addr_t rd, input sb_pkg::reg_addr_t rs1,
                           input sb_pkg::reg_addr_t rs2, input sb_pkg::data_t imm_set);
    sb_pkg::data_t imm;
    sb_pkg::data_t a;
    sb_pkg::data_t b;
    sb_pkg::data_t res;
    imm = '0;
    if (op == sb_pkg::OP_LI) begin
      take_bits(`XLEN, imm);
      imm = imm | imm_set;
    end
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    case (op)
      sb_pkg::OP_LI:  res = imm;
      sb_pkg::OP_ADD: res = a + b;
      sb_pkg::OP_SUB: res = a - b;
      sb_pkg::OP_AND: res = a & b;
      sb_pkg::OP_XOR: res = a ^ b;
      default:        res = a * b;
    endcase
    // x0 retires its value but never holds it
    if (rd != '0) begin
      ref_regs[rd] = res;
    end
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_rd.push_back(rd);
    tbl_rs1.push_back(rs1);
    tbl_rs2.push_back(rs2);
    tbl_imm.push_back(imm);
    exp_name.push_back(name);
    exp_rd.push_back(rd);
    exp_data.push_back(res);
  endtask

  task automatic build_table;
    sb_pkg::data_t top_bit;
    top_bit = {1'b1, {(`XLEN-1){1'b0}}};
    ref_regs = '{default: '0};
    add_instr("li", sb_pkg::OP_LI, 1, 0, 0, '0);
    add_instr("li", sb_pkg::OP_LI, 2, 0, 0, '0);
    add_instr("li", sb_pkg::OP_LI, 3, 0, 0, '0);
    add_instr("li", sb_pkg::OP_LI, 4, 0, 0, '0);
    // back to back and two back dependencies
    add_instr("chain", sb_pkg::OP_ADD, 5, 1, 2, '0);
    add_instr("chain", sb_pkg::OP_SUB, 6, 5, 3, '0);
    add_instr("chain", sb_pkg::OP_AND, 7, 6, 4, '0);
    add_instr("chain", sb_pkg::OP_XOR, 8, 7, 6, '0);
    add_instr("chain", sb_pkg::OP_ADD, 8, 8, 8, '0);
    add_instr("chain", sb_pkg::OP_SUB, 9, 1, 8, '0);
    // long mul with younger alu work behind it
    add_instr("mul", sb_pkg::OP_LI, 10, 0, 0, '0);
    add_instr("mul", sb_pkg::OP_LI, 11, 0, 0, top_bit);
    add_instr("mul", sb_pkg::OP_MUL, 12, 10, 11, '0);
    add_instr("mul", sb_pkg::OP_ADD, 13, 1, 2, '0);
    add_instr("mul", sb_pkg::OP_XOR, 14, 3, 4, '0);
    add_instr("mul", sb_pkg::OP_MUL, 15, 8, 9, '0);
    add_instr("mul", sb_pkg::OP_ADD, 16, 12, 15, '0);
    // table fills up behind a blocked head
    add_instr("depth", sb_pkg::OP_MUL, 17, 11, 11, '0);
    add_instr("depth", sb_pkg::OP_LI, 18, 0, 0, '0);
    add_instr("depth", sb_pkg::OP_LI, 19, 0, 0, '0);
    add_instr("depth", sb_pkg::OP_LI, 20, 0, 0, '0);
    add_instr("depth", sb_pkg::OP_LI, 21, 0, 0, '0);
    add_instr("depth", sb_pkg::OP_LI, 22, 0, 0, '0);
    add_instr("depth", sb_pkg::OP_ADD, 23, 17, 22, '0);
    // writes to x0
    add_instr("x0", sb_pkg::OP_LI, 0, 0, 0, '0);
    add_instr("x0", sb_pkg::OP_ADD, 24, 0, 1, '0);
    add_instr("x0", sb_pkg::OP_MUL, 0, 10, 11, '0);
    add_instr("x0", sb_pkg::OP_XOR, 25, 0, 2, '0);
    add_instr("x0", sb_pkg::OP_SUB, 0, 1, 2, '0);
    add_instr("x0", sb_pkg::OP_ADD, 26, 3, 0, '0);
  endtask

  // ------------------------------
  // driver and checks
  // ------------------------------
  task automatic drive_instr(input int i);
    logic accepted;
    @(negedge clock);
    instr_valid_i = 1'b1;
    op_i = tbl_op[i];
    rd_i = tbl_rd[i];
    rs1_i = tbl_rs1[i];
    rs2_i = tbl_rs2[i];
    imm_i = tbl_imm[i];
    accepted = 1'b0;
    // inputs stay put until the ack edge
    while (!accepted) begin
      @(posedge clock);
      accepted = instr_ack_o;
    end
  endtask

  task automatic check_idle(input string name);
    assert (!instr_ack_o && !commit_valid_o) else begin
      mismatch_errors++;
      $display("MISMATCH %s: expected ack 0 commit 0, actual ack %b commit %b",
               name, instr_ack_o, commit_valid_o);
    end
  endtask

  task automatic check_commit;
    string name;
    sb_pkg::reg_addr_t rd;
    sb_pkg::data_t data;
    assert (exp_rd.size() > 0) else begin
      other_errors++;
      $display("extra commit of x%0d after every instruction already retired",
               commit_rd_o);
    end
    if (exp_rd.size() > 0) begin
      name = exp_name.pop_front();
      rd = exp_rd.pop_front();
      data = exp_data.pop_front();
      assert (commit_rd_o == rd && commit_data_o == data) else begin
        mismatch_errors++;
        $display("MISMATCH %s: expected x%0d = %h, actual x%0d = %h",
                 name, rd, data, commit_rd_o, commit_data_o);
      end
      committed_cnt++;
    end
  endtask

  task automatic report_counts;
    $display("errors: %0d mismatches, %0d other failures, %0d of %0d committed",
             mismatch_errors, other_errors, committed_cnt, tbl_op.size());
  endtask

  // values seen here are the ones present just before the edge
  always @(posedge clock) begin
    if (!reset) begin
      if (instr_valid_i && instr_ack_o) begin
        accepted_cnt++;
      end
      if (commit_valid_o) begin
        check_commit();
      end
      assert (accepted_cnt - committed_cnt <= `SB_DEPTH) else begin
        other_errors++;
        $display("%0d instructions in flight, more than the %0d slots",
                 accepted_cnt - committed_cnt, `SB_DEPTH);
      end
    end
  end

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial begin
    lfsr_q = 32'ha095;
    table_ready = 1'b0;
    mismatch_errors = 0;
    other_errors = 0;
    accepted_cnt = 0;
    committed_cnt = 0;
    reset = 1'b1;
    instr_valid_i = 1'b0;
    op_i = sb_pkg::OP_LI;
    rd_i = '0;
    rs1_i = '0;
    rs2_i = '0;
    imm_i = '0;
    build_table();
    table_ready = 1'b1;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clock);
      // table state is defined once the first reset edge has passed
      if (c > 0) begin
        check_idle("reset");
      end
    end
    @(negedge clock);
    reset = 1'b0;
    @(posedge clock);
    check_idle("after reset");
    for (int i = 0; i < tbl_op.size(); i++) begin
      drive_instr(i);
    end
    @(negedge clock);
    instr_valid_i = 1'b0;
    wait (committed_cnt == tbl_op.size());
    // catch any late duplicate commit
    repeat (4) @(posedge clock);
    report_counts();
    if (mismatch_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (table_ready);
    limit = RESET_CYCLES + tbl_op.size() * (`XLEN + 8);
    repeat (limit) @(posedge clock);
    other_errors++;
    $display("timeout after %0d cycles, not every instruction retired", limit);
    for (int i = committed_cnt; i < tbl_op.size(); i++) begin
      $display("instruction %0d (%s) never committed", i, tbl_name[i]);
    end
    report_counts();
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
design/sb_pkg.sv
design/alu_unit.sv
design/mult_unit.sv
design/reg_file.sv
design/scoreboard.sv
design/operand_read.sv
design/backend_top.sv
tests/backend_tb.sv
